/* verilog/uart_macros.svh */
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// register map on the 3-bit bus address
`define UART_BAUD_L_ADDR       3'd0
`define UART_BAUD_H_ADDR       3'd1
`define UART_STATUS_ADDR       3'd2
`define UART_DATA_ADDR         3'd3
`define UART_INT_ADDR          3'd4
`define UART_INT_PENDING_ADDR  3'd5

// bit positions in the interrupt enable and pending registers
`define UART_INT_RX_READY      0
`define UART_INT_TX_EMPTY      1

// default entries per FIFO
`define UART_FIFO_DEPTH        4

`endif

/* verilog/uart_pkg.sv */
package uart_pkg;

    // one data byte on the bus and on the line
    typedef logic [7:0] uart_byte_t;

    // bit period minus one, in clock cycles
    typedef logic [15:0] baud_div_t;

    // register address on the bus
    typedef logic [2:0] reg_addr_t;

    // receive FIFO payload
    typedef struct packed {
        uart_byte_t data;
        logic       frame_err;      // stop bit read low
    } rx_entry_t;

endpackage : uart_pkg

/* verilog/uart_fifo.sv */
`timescale 1ns/100ps
`include "uart_macros.svh"

module uart_fifo
#(
    parameter type T     = uart_pkg::uart_byte_t,
    parameter int  DEPTH = `UART_FIFO_DEPTH
)
(
    input  logic clk,
    input  logic rst,
    input  logic i_push,
    input  T     i_data,
    input  logic i_pop,
    output T     o_data,
    output logic o_full,
    output logic o_empty
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;           // occupancy
    logic          do_push;
    logic          do_pop;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;     // wrap for any depth
    endfunction

    assign o_full  = (count == CW'(DEPTH));
    assign o_empty = (count == '0);
    assign o_data  = mem[rd_ptr];   // head entry

    assign do_pop  = i_pop && !o_empty;
    assign do_push = i_push && (!o_full || do_pop);  // pop frees a slot

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= i_data;
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // both consumers check empty before popping
    a_pop_not_empty: assert property (@(posedge clk) disable iff (!rst)
        i_pop |-> !o_empty);

    // an entry pushed onto a full FIFO is lost
    a_push_not_full: assert property (@(posedge clk) disable iff (!rst)
        i_push |-> !o_full || i_pop);

endmodule

/* verilog/uart_tx.sv */
`timescale 1ns/100ps

module uart_tx
(
    input  logic                 clk,
    input  logic                 rst,
    input  uart_pkg::baud_div_t  i_baud_div,
    input  logic                 i_empty,
    input  uart_pkg::uart_byte_t i_data,
    output logic                 o_pop,
    output logic                 o_tx_pin
);
    import uart_pkg::*;

    typedef enum logic {IDLE, SHIFT} tx_state_t;

    tx_state_t  state;
    baud_div_t  baud_cnt;           // cycles left in this bit
    logic [3:0] bit_cnt;            // 0 = start, 9 = stop
    logic [9:0] shift_reg;
    logic       bit_end;

    assign bit_end  = (baud_cnt == '0);
    assign o_pop    = (state == IDLE) && !i_empty;
    assign o_tx_pin = (state == SHIFT) ? shift_reg[0] : 1'b1;   // line idles high

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state    <= IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (o_pop)
                    begin
                        baud_cnt <= i_baud_div;
                        bit_cnt  <= '0;
                        state    <= SHIFT;  // start bit next cycle
                    end
                end
                SHIFT:
                begin
                    if (bit_end)
                    begin
                        baud_cnt <= i_baud_div;
                        bit_cnt  <= bit_cnt + 4'd1;
                        if (bit_cnt == 4'd9)
                            state <= IDLE;  // stop bit done
                    end
                    else
                    begin
                        baud_cnt <= baud_cnt - 1'b1;
                    end
                end
            endcase
        end
    end

    // frame is stop, data lsb first, start, shifted out from bit 0
    always_ff @(posedge clk)
    begin
        if (o_pop)
            shift_reg <= {1'b1, i_data, 1'b0};
        else if (state == SHIFT && bit_end)
            shift_reg <= {1'b1, shift_reg[9:1]};
    end

    // a frame is at least ten cycles long even at divisor zero
    a_no_pop_in_frame: assert property (@(posedge clk) disable iff (!rst)
        o_pop |=> !o_pop [*10]);

endmodule

/* verilog/uart_rx.sv */
`timescale 1ns/100ps

module uart_rx
(
    input  logic                 clk,
    input  logic                 rst,
    input  uart_pkg::baud_div_t  i_baud_div,
    input  logic                 i_rx_pin,
    output logic                 o_push,
    output uart_pkg::rx_entry_t  o_entry
);
    import uart_pkg::*;

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} rx_state_t;

    rx_state_t  state;
    logic       rx_q;               // pin after one register
    logic       rx_prev;
    baud_div_t  baud_cnt;
    logic [2:0] bit_cnt;
    uart_byte_t shift_reg;
    logic       sample;

    assign sample = (baud_cnt == '0);

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            rx_q    <= 1'b1;
            rx_prev <= 1'b1;
        end
        else
        begin
            rx_q    <= i_rx_pin;
            rx_prev <= rx_q;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state    <= IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            o_push   <= 1'b0;
        end
        else
        begin
            o_push <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (rx_prev && !rx_q)
                    begin
                        baud_cnt <= i_baud_div >> 1;    // half period to mid start bit
                        state    <= START;
                    end
                end
                START:
                begin
                    if (!sample)
                    begin
                        baud_cnt <= baud_cnt - 1'b1;
                    end
                    else if (!rx_q)
                    begin
                        baud_cnt <= i_baud_div;
                        bit_cnt  <= '0;
                        state    <= DATA;
                    end
                    else
                    begin
                        state <= IDLE;  // glitch, not a start bit
                    end
                end
                DATA:
                begin
                    if (sample)
                    begin
                        baud_cnt <= i_baud_div;
                        bit_cnt  <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7)
                            state <= STOP;
                    end
                    else
                    begin
                        baud_cnt <= baud_cnt - 1'b1;
                    end
                end
                STOP:
                begin
                    if (sample)
                    begin
                        o_push <= 1'b1;     // middle of stop bit
                        state  <= IDLE;
                    end
                    else
                    begin
                        baud_cnt <= baud_cnt - 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == DATA && sample)
            shift_reg <= {rx_q, shift_reg[7:1]};    // lsb arrives first
        if (state == STOP && sample)
        begin
            o_entry.data      <= shift_reg;
            o_entry.frame_err <= !rx_q;             // stop bit should be high
        end
    end

    // the receive FIFO takes one entry per frame
    a_push_single: assert property (@(posedge clk) disable iff (!rst)
        o_push |=> !o_push);

endmodule

/* verilog/uart_mem.sv */
`timescale 1ns/100ps
`include "uart_macros.svh"

module uart_mem
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_enable,
    input  logic                 i_wr_en,
    input  uart_pkg::reg_addr_t  i_addr,
    input  uart_pkg::uart_byte_t i_data,
    output logic                 o_ready,
    output uart_pkg::uart_byte_t o_data,
    output logic                 o_irq,
    output logic                 o_tx_push,
    output uart_pkg::uart_byte_t o_tx_data,
    input  logic                 i_tx_full,
    input  logic                 i_tx_empty,
    output logic                 o_rx_pop,
    input  uart_pkg::rx_entry_t  i_rx_entry,
    input  logic                 i_rx_empty,
    output uart_pkg::baud_div_t  o_baud_div
);
    import uart_pkg::*;

    typedef enum logic {ISSUE, RETIRE} bus_state_t;

    bus_state_t state;
    baud_div_t  baud_div;
    logic [1:0] int_enables;
    logic [1:0] int_pending;
    logic [1:0] int_set;            // rising edges this cycle
    logic       rx_avail;
    logic       rx_avail_prev;
    logic       tx_empty_prev;
    logic       issue;
    uart_byte_t status;

    assign rx_avail = !i_rx_empty;
    assign issue    = i_enable && !o_ready && (state == ISSUE);
    assign status   = {5'b0, i_rx_entry.frame_err & rx_avail, i_tx_full, rx_avail};

    assign int_set[`UART_INT_RX_READY] = rx_avail && !rx_avail_prev;
    assign int_set[`UART_INT_TX_EMPTY] = i_tx_empty && !tx_empty_prev;

    assign o_irq      = |(int_enables & int_pending);
    assign o_baud_div = baud_div;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state         <= ISSUE;
            baud_div      <= '0;
            int_enables   <= '0;
            int_pending   <= '0;
            rx_avail_prev <= 1'b0;
            tx_empty_prev <= 1'b1;  // FIFO starts empty, no edge
            o_ready       <= 1'b0;
            o_tx_push     <= 1'b0;
            o_rx_pop      <= 1'b0;
        end
        else
        begin
            rx_avail_prev <= rx_avail;
            tx_empty_prev <= i_tx_empty;
            int_pending   <= int_pending | int_set;

            if (i_enable && !o_ready)
            begin
                case (state)
                    ISSUE:
                    begin
                        if (i_wr_en)
                        begin
                            case (i_addr)
                                `UART_BAUD_L_ADDR: baud_div[7:0] <= i_data;
                                `UART_BAUD_H_ADDR: baud_div[15:8] <= i_data;
                                `UART_DATA_ADDR:   o_tx_push <= !i_tx_full;  // full drops the byte
                                `UART_INT_ADDR:    int_enables <= i_data[1:0];
                                `UART_INT_PENDING_ADDR:
                                begin
                                    // write ones to clear, a new edge still wins
                                    int_pending <= (int_pending & ~i_data[1:0]) | int_set;
                                end
                                default: ;
                            endcase
                        end
                        else if (i_addr == `UART_DATA_ADDR)
                        begin
                            o_rx_pop <= rx_avail;
                        end
                        state <= RETIRE;
                    end
                    RETIRE:
                    begin
                        o_tx_push <= 1'b0;  // strobes last one cycle
                        o_rx_pop  <= 1'b0;
                        o_ready   <= 1'b1;
                    end
                endcase
            end
            else if (!i_enable)
            begin
                o_ready <= 1'b0;
                state   <= ISSUE;
            end
        end
    end

    // read data and transmit byte, captured at issue
    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            o_tx_data <= i_data;
            if (!i_wr_en)
            begin
                case (i_addr)
                    `UART_BAUD_L_ADDR:      o_data <= baud_div[7:0];
                    `UART_BAUD_H_ADDR:      o_data <= baud_div[15:8];
                    `UART_STATUS_ADDR:      o_data <= status;
                    `UART_DATA_ADDR:        o_data <= rx_avail ? i_rx_entry.data : '0;
                    `UART_INT_ADDR:         o_data <= {6'b0, int_enables};
                    `UART_INT_PENDING_ADDR: o_data <= {6'b0, int_pending};
                    default:                o_data <= '0;
                endcase
            end
        end
    end

    // ready holds until the master has dropped enable
    a_ready_hold: assert property (@(posedge clk) disable iff (!rst)
        $fell(o_ready) |-> $past(!i_enable));

endmodule

/* verilog/uart_top.sv */
`timescale 1ns/100ps

module uart_top
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_enable,
    input  logic                 i_wr_en,
    input  uart_pkg::reg_addr_t  i_addr,
    input  uart_pkg::uart_byte_t i_data,
    output logic                 o_ready,
    output uart_pkg::uart_byte_t o_data,
    output logic                 o_irq,
    input  logic                 i_rx_pin,
    output logic                 o_tx_pin
);
    import uart_pkg::*;

    baud_div_t  baud_div;

    logic       tx_push;
    uart_byte_t tx_wr_data;
    logic       tx_pop;
    uart_byte_t tx_head;
    logic       tx_full;
    logic       tx_empty;

    logic       rx_push;
    rx_entry_t  rx_wr_entry;
    logic       rx_pop;
    rx_entry_t  rx_head;
    logic       rx_empty;

    uart_mem u_uart_mem
    (
        .clk        (clk),
        .rst        (rst),
        .i_enable   (i_enable),
        .i_wr_en    (i_wr_en),
        .i_addr     (i_addr),
        .i_data     (i_data),
        .o_ready    (o_ready),
        .o_data     (o_data),
        .o_irq      (o_irq),
        .o_tx_push  (tx_push),
        .o_tx_data  (tx_wr_data),
        .i_tx_full  (tx_full),
        .i_tx_empty (tx_empty),
        .o_rx_pop   (rx_pop),
        .i_rx_entry (rx_head),
        .i_rx_empty (rx_empty),
        .o_baud_div (baud_div)
    );

    uart_fifo #(.T(uart_byte_t)) u_tx_fifo
    (
        .clk     (clk),
        .rst     (rst),
        .i_push  (tx_push),
        .i_data  (tx_wr_data),
        .i_pop   (tx_pop),
        .o_data  (tx_head),
        .o_full  (tx_full),
        .o_empty (tx_empty)
    );

    uart_tx u_uart_tx
    (
        .clk        (clk),
        .rst        (rst),
        .i_baud_div (baud_div),
        .i_empty    (tx_empty),
        .i_data     (tx_head),
        .o_pop      (tx_pop),
        .o_tx_pin   (o_tx_pin)
    );

    uart_rx u_uart_rx
    (
        .clk        (clk),
        .rst        (rst),
        .i_baud_div (baud_div),
        .i_rx_pin   (i_rx_pin),
        .o_push     (rx_push),
        .o_entry    (rx_wr_entry)
    );

    // full is not needed here, the FIFO drops on overflow
    uart_fifo #(.T(rx_entry_t)) u_rx_fifo
    (
        .clk     (clk),
        .rst     (rst),
        .i_push  (rx_push),
        .i_data  (rx_wr_entry),
        .i_pop   (rx_pop),
        .o_data  (rx_head),
        .o_full  (),
        .o_empty (rx_empty)
    );

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock
#(
    parameter real PERIOD = 4.0     // ns
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD / 2.0) clk = ~clk;
    end

endmodule

/* bench/uart_tb.sv */
`timescale 1ns/100ps
`include "uart_macros.svh"

module uart_tb;
    import uart_pkg::*;

    localparam int BIT_CYCLES     = 8;                      // divisor 7
    localparam int FRAME_CYCLES   = 10 * BIT_CYCLES;
    localparam int BUS_LIMIT      = 32;
    // about 25 frame times of traffic, ten times over
    localparam int TIMEOUT_CYCLES = 25 * FRAME_CYCLES * 10;
    localparam int STAT_RX_AVAIL  = 0;
    localparam int STAT_TX_FULL   = 1;
    localparam int STAT_FRAME_ERR = 2;
    localparam int TX_ACCEPTED    = `UART_FIFO_DEPTH + 1;   // FIFO plus the byte in flight
    localparam int TX_WRITTEN     = `UART_FIFO_DEPTH + 3;

    logic       clk;
    logic       rst;
    logic       enable;
    logic       wr_en;
    reg_addr_t  addr;
    uart_byte_t wdata;
    logic       ready;
    uart_byte_t rdata;
    logic       irq;
    logic       tx_pin;
    logic       rx_pin;
    logic       loopback;           // tx pin feeds rx pin
    logic       line_rx;            // serial line model

    uart_byte_t tx_seen[$];         // bytes decoded from the tx pin
    int         errors;
    int         tests_ok;
    int         tests_bad;
    int         cycle_count;

    assign rx_pin = loopback ? tx_pin : line_rx;

    tb_clock u_tb_clock (.clk(clk));

    uart_top u_uart_top
    (
        .clk      (clk),
        .rst      (rst),
        .i_enable (enable),
        .i_wr_en  (wr_en),
        .i_addr   (addr),
        .i_data   (wdata),
        .o_ready  (ready),
        .o_data   (rdata),
        .o_irq    (irq),
        .i_rx_pin (rx_pin),
        .o_tx_pin (tx_pin)
    );

    task automatic step();
        @(posedge clk);
        #1;                         // drive and sample off the edge
    endtask

    function automatic uart_byte_t rand_byte();
        return uart_byte_t'($urandom());
    endfunction

    task automatic expect_byte(input string what, input uart_byte_t got, input uart_byte_t exp);
        assert (got === exp)
        else
        begin
            $display("FAILED %0t ns: %s read %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic expect_level(input string what, input logic got, input logic exp);
        assert (got === exp)
        else
        begin
            $display("FAILED %0t ns: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic bus_access(input logic wr, input reg_addr_t a, input uart_byte_t d,
                              output uart_byte_t q);
        int n;
        enable = 1'b1;
        wr_en  = wr;
        addr   = a;
        wdata  = d;
        n = 0;
        step();
        while (!ready && n < BUS_LIMIT)
        begin
            step();
            n++;
        end
        assert (ready)
        else
        begin
            $display("bus gave no ready within %0d cycles at address %0d", BUS_LIMIT, a);
            errors++;
        end
        q      = rdata;
        enable = 1'b0;
        wr_en  = 1'b0;
        n = 0;
        step();
        while (ready && n < BUS_LIMIT)
        begin
            step();
            n++;
        end
        assert (!ready)
        else
        begin
            $display("bus kept ready high after enable was dropped");
            errors++;
        end
    endtask

    task automatic bus_write(input reg_addr_t a, input uart_byte_t d);
        uart_byte_t unused;
        bus_access(1'b1, a, d, unused);
    endtask

    task automatic bus_read(input reg_addr_t a, output uart_byte_t q);
        bus_access(1'b0, a, 8'h00, q);
    endtask

    task automatic set_divisor(input baud_div_t div);
        bus_write(`UART_BAUD_L_ADDR, div[7:0]);
        bus_write(`UART_BAUD_H_ADDR, div[15:8]);
    endtask

    task automatic wait_tx_frames(input int n);
        int cycles;
        cycles = 0;
        while (tx_seen.size() < n && cycles < 2 * n * FRAME_CYCLES)
        begin
            step();
            cycles++;
        end
        assert (tx_seen.size() >= n)
        else
        begin
            $display("only %0d of %0d frames came out on the tx pin", tx_seen.size(), n);
            errors++;
        end
    endtask

    task automatic wait_irq();
        int cycles;
        cycles = 0;
        while (!irq && cycles < 2 * FRAME_CYCLES)
        begin
            step();
            cycles++;
        end
        assert (irq)
        else
        begin
            $display("irq did not rise within %0d cycles", 2 * FRAME_CYCLES);
            errors++;
        end
    endtask

    task automatic wait_rx_data();
        uart_byte_t st;
        int         polls;
        polls = 0;
        bus_read(`UART_STATUS_ADDR, st);
        while (!st[STAT_RX_AVAIL] && polls < 64)
        begin
            bus_read(`UART_STATUS_ADDR, st);
            polls++;
        end
        assert (st[STAT_RX_AVAIL])
        else
        begin
            $display("no received byte showed up in the status register");
            errors++;
        end
    endtask

    // start bit, data lsb first, then the given stop level
    task automatic send_line_frame(input uart_byte_t b, input logic stop);
        int k;
        for (k = 0; k < 10; k++)
        begin
            if (k == 0)
                line_rx = 1'b0;
            else if (k == 9)
                line_rx = stop;
            else
                line_rx = b[k-1];
            repeat (BIT_CYCLES) step();
        end
        line_rx = 1'b1;
    endtask

    // called on the first low cycle, every bit must hold for a full period
    task automatic decode_tx_frame();
        uart_byte_t b;
        logic       first;
        int         k;
        int         c;
        for (k = 0; k < 10; k++)
        begin
            first = tx_pin;
            for (c = 0; c < BIT_CYCLES; c++)
            begin
                if (k == 0)
                    expect_level("tx start bit", tx_pin, 1'b0);
                else if (k == 9)
                    expect_level("tx stop bit", tx_pin, 1'b1);
                else
                    expect_level("tx data bit", tx_pin, first);
                step();
            end
            if (k >= 1 && k <= 8)
                b[k-1] = first;
        end
        tx_seen.push_back(b);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before)
        begin
            tests_ok++;
            $display("%0t ns  %s: ok", $time, name);
        end
        else
        begin
            tests_bad++;
            $display("%0t ns  %s: %0d errors", $time, name, errors - errors_before);
        end
    endtask

    task automatic register_access();
        int         e0;
        uart_byte_t q;
        uart_byte_t lo;
        uart_byte_t hi;
        uart_byte_t en;
        e0 = errors;
        lo = rand_byte();
        hi = rand_byte();
        en = rand_byte() & 8'h03;   // two enable bits
        bus_read(`UART_STATUS_ADDR, q);
        expect_byte("status after reset", q, 8'h00);
        bus_read(`UART_BAUD_L_ADDR, q);
        expect_byte("divisor low after reset", q, 8'h00);
        bus_read(`UART_BAUD_H_ADDR, q);
        expect_byte("divisor high after reset", q, 8'h00);
        bus_read(`UART_INT_PENDING_ADDR, q);
        expect_byte("pending after reset", q, 8'h00);
        bus_write(`UART_BAUD_L_ADDR, lo);
        bus_write(`UART_BAUD_H_ADDR, hi);
        bus_write(`UART_INT_ADDR, en);
        bus_read(`UART_BAUD_L_ADDR, q);
        expect_byte("divisor low", q, lo);
        bus_read(`UART_BAUD_H_ADDR, q);
        expect_byte("divisor high", q, hi);
        bus_read(`UART_INT_ADDR, q);
        expect_byte("interrupt enables", q, en);
        bus_write(`UART_INT_ADDR, 8'h00);
        finish_test("register access", e0);
    endtask

    task automatic transmit_framing();
        int         e0;
        int         i;
        uart_byte_t b[3];
        e0 = errors;
        set_divisor(16'(BIT_CYCLES - 1));
        tx_seen.delete();
        for (i = 0; i < 3; i++)
        begin
            b[i] = rand_byte();
            bus_write(`UART_DATA_ADDR, b[i]);
            wait_tx_frames(i + 1);
            if (tx_seen.size() > i)
                expect_byte("byte on tx pin", tx_seen[i], b[i]);
        end
        finish_test("transmit framing", e0);
    endtask

    task automatic loopback_order();
        int         e0;
        int         i;
        uart_byte_t q;
        uart_byte_t b[4];
        e0 = errors;
        loopback = 1'b1;
        tx_seen.delete();
        for (i = 0; i < 4; i++)
        begin
            b[i] = rand_byte();
            bus_write(`UART_DATA_ADDR, b[i]);
        end
        wait_tx_frames(4);
        repeat (BIT_CYCLES) step();     // last push lands mid stop bit
        wait_rx_data();
        for (i = 0; i < 4; i++)
        begin
            bus_read(`UART_STATUS_ADDR, q);
            expect_level("rx data flag", q[STAT_RX_AVAIL], 1'b1);
            expect_level("frame error flag", q[STAT_FRAME_ERR], 1'b0);
            bus_read(`UART_DATA_ADDR, q);
            expect_byte("loopback byte", q, b[i]);
        end
        bus_read(`UART_STATUS_ADDR, q);
        expect_level("rx data flag after last read", q[STAT_RX_AVAIL], 1'b0);
        finish_test("loopback receive order", e0);
    endtask

    task automatic interrupt_flags();
        int         e0;
        uart_byte_t q;
        uart_byte_t b1;
        uart_byte_t b2;
        e0 = errors;
        tx_seen.delete();
        bus_write(`UART_INT_PENDING_ADDR, 8'h03);
        bus_write(`UART_INT_ADDR, 8'(1 << `UART_INT_RX_READY));
        expect_level("irq with nothing pending", irq, 1'b0);
        b1 = rand_byte();
        bus_write(`UART_DATA_ADDR, b1);
        wait_irq();
        expect_level("irq on rx ready", irq, 1'b1);
        bus_read(`UART_INT_PENDING_ADDR, q);
        expect_level("rx ready pending", q[`UART_INT_RX_READY], 1'b1);
        bus_write(`UART_INT_PENDING_ADDR, 8'h03);
        expect_level("irq after clearing pending", irq, 1'b0);
        bus_read(`UART_DATA_ADDR, q);
        expect_byte("byte behind rx interrupt", q, b1);

        bus_write(`UART_INT_ADDR, 8'(1 << `UART_INT_TX_EMPTY));
        expect_level("irq before tx traffic", irq, 1'b0);
        b2 = rand_byte();
        bus_write(`UART_DATA_ADDR, b2);
        wait_irq();                     // FIFO drains once the serializer pops
        expect_level("irq on tx empty", irq, 1'b1);
        bus_read(`UART_INT_PENDING_ADDR, q);
        expect_level("tx empty pending", q[`UART_INT_TX_EMPTY], 1'b1);
        bus_write(`UART_INT_PENDING_ADDR, 8'h03);
        expect_level("irq after clearing tx empty", irq, 1'b0);

        wait_tx_frames(2);
        repeat (BIT_CYCLES) step();
        wait_rx_data();
        bus_read(`UART_DATA_ADDR, q);
        expect_byte("byte behind tx interrupt", q, b2);
        bus_write(`UART_INT_ADDR, 8'h00);
        bus_write(`UART_INT_PENDING_ADDR, 8'h03);
        finish_test("interrupts", e0);
    endtask

    task automatic frame_error();
        int         e0;
        uart_byte_t q;
        uart_byte_t b;
        e0 = errors;
        loopback = 1'b0;
        b = rand_byte();
        send_line_frame(b, 1'b0);
        repeat (2 * BIT_CYCLES) step();
        wait_rx_data();
        bus_read(`UART_STATUS_ADDR, q);
        expect_level("frame error flag", q[STAT_FRAME_ERR], 1'b1);
        bus_read(`UART_DATA_ADDR, q);
        expect_byte("byte with low stop bit", q, b);
        bus_read(`UART_STATUS_ADDR, q);
        expect_byte("status after draining", q, 8'h00);
        finish_test("frame error", e0);
    endtask

    task automatic transmit_overflow();
        int         e0;
        int         i;
        uart_byte_t q;
        uart_byte_t b[TX_WRITTEN];
        e0 = errors;
        tx_seen.delete();
        for (i = 0; i < TX_WRITTEN; i++)
        begin
            b[i] = rand_byte();
            bus_write(`UART_DATA_ADDR, b[i]);
        end
        bus_read(`UART_STATUS_ADDR, q);
        expect_level("tx full flag", q[STAT_TX_FULL], 1'b1);
        wait_tx_frames(TX_ACCEPTED);
        repeat (3 * FRAME_CYCLES) step();   // dropped bytes would show up here
        assert (tx_seen.size() == TX_ACCEPTED)
        else
        begin
            $display("FAILED %0t ns: %0d frames on tx pin, expected %0d",
                     $time, tx_seen.size(), TX_ACCEPTED);
            errors++;
        end
        for (i = 0; i < TX_ACCEPTED && i < tx_seen.size(); i++)
            expect_byte("accepted byte on tx pin", tx_seen[i], b[i]);
        bus_read(`UART_STATUS_ADDR, q);
        expect_level("tx full flag after draining", q[STAT_TX_FULL], 1'b0);
        finish_test("transmit overflow", e0);
    endtask

    // line decoder for the tx pin
    initial
    begin
        wait (rst === 1'b1);
        forever
        begin
            step();
            if (tx_pin === 1'b0)
                decode_tx_frame();
        end
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run stopped at the limit of %0d cycles, a test is stuck", TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        void'($urandom(32'h09687c31));
        errors    = 0;
        tests_ok  = 0;
        tests_bad = 0;
        rst       = 1'b0;
        enable    = 1'b0;
        wr_en     = 1'b0;
        addr      = '0;
        wdata     = '0;
        loopback  = 1'b0;
        line_rx   = 1'b1;       // line idles high
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b1;

        register_access();
        transmit_framing();
        loopback_order();
        interrupt_flags();
        frame_error();
        transmit_overflow();

        $display("tests ok: %0d, tests with errors: %0d, check errors: %0d",
                 tests_ok, tests_bad, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* src.f */
+incdir+verilog
verilog/uart_pkg.sv
verilog/uart_fifo.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_mem.sv
verilog/uart_top.sv
bench/tb_clock.sv
bench/uart_tb.sv

/* Bender.yml */
package:
  name: uart_mem

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/uart_pkg.sv
      - verilog/uart_fifo.sv
      - verilog/uart_tx.sv
      - verilog/uart_rx.sv
      - verilog/uart_mem.sv
      - verilog/uart_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/tb_clock.sv
      - bench/uart_tb.sv
